// ==== hdl/credit_link_defs.svh ====
/*
  Build-time parameters for the credit link.
  CL_MAX_CREDIT must be at least 1; it sets both the credit pool and the
  receiver buffer depth, so the two always agree.
  CL_REG_POP takes 0 or 1 only.
*/
`ifndef CREDIT_LINK_DEFS_SVH
`define CREDIT_LINK_DEFS_SVH

// Flit data width in bits.
`define CL_WIDTH 8

// Total credits in circulation, equal to the receiver buffer depth.
`define CL_MAX_CREDIT 4

// When 1, the sender link outputs pass through one register stage.
`define CL_REG_POP 1

// Width of a credit count, wide enough to hold CL_MAX_CREDIT itself.
`define CL_CNT_W ($clog2(`CL_MAX_CREDIT + 1))

`endif

// ==== hdl/credit_link_pkg.sv ====
/*
  Shared types for the credit link.
  Widths come from the defs header, so a change there reaches every block.
*/
`default_nettype none

`include "credit_link_defs.svh"

package credit_link_pkg;

  // One flit of payload on the link.
  typedef logic [`CL_WIDTH-1:0] flit_t;

  // A credit count, from zero up to CL_MAX_CREDIT inclusive.
  typedef logic [`CL_CNT_W-1:0] credit_t;

  // Counter operation for one cycle.
  // SWAP means a credit came back and one was spent at the same edge.
  typedef enum logic [1:0] {
    CNT_HOLD = 2'b00,
    CNT_INC  = 2'b01,
    CNT_DEC  = 2'b10,
    CNT_SWAP = 2'b11
  } cnt_op_e;

endpackage

`default_nettype wire

// ==== hdl/credit_counter.sv ====
/*
  Credit counter for the sender side of the link.
  The count loads CL_MAX_CREDIT at reset; there is no initial-value port.
  Increment and decrement are by one credit each and may coincide.
  The caller must not increment a full counter without a decrement.
*/
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_counter import credit_link_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    incr_valid,
  input  logic    decr_valid,
  output logic    decr_ready,
  input  credit_t withhold,
  output credit_t value,
  output credit_t available
);

  cnt_op_e op;
  logic    decr_xfer;

  // ----------------------------------------------------------
  // Availability
  // ----------------------------------------------------------

  // Withheld credits are removed from what may be spent.
  // The difference saturates at zero when withhold exceeds the count.
  assign available = (value > withhold) ? (value - withhold) : '0;

  // A credit returning this cycle may be spent at once.
  assign decr_ready = (available != '0) || incr_valid;
  assign decr_xfer  = decr_valid && decr_ready;

  // ----------------------------------------------------------
  // Update
  // ----------------------------------------------------------

  // Decode this cycle's events into one operation.
  always_comb begin
    case ({decr_xfer, incr_valid})
      2'b01:   op = CNT_INC;
      2'b10:   op = CNT_DEC;
      2'b11:   op = CNT_SWAP;
      default: op = CNT_HOLD;
    endcase
  end

  // The pool starts full, since the receiver buffer is empty at reset.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= credit_t'(`CL_MAX_CREDIT);
    end else begin
      case (op)
        CNT_INC: value <= value + credit_t'(1);
        CNT_DEC: value <= value - credit_t'(1);
        // HOLD and SWAP both leave the count as it is.
        default: value <= value;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/credit_sender.sv ====
/*
  Credit sender: ready/valid push in, valid strobe and data out to the link.
  One credit is spent per flit; credits return as single-cycle pulses.
  push_ready stays low during reset and for the first cycle after it.
  With CL_REG_POP = 1 the link outputs lag the push transfer by one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_sender import credit_link_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    push_valid,
  input  flit_t   push_data,
  output logic    push_ready,
  input  logic    link_credit,
  output logic    link_valid,
  output flit_t   link_data,
  input  credit_t credit_withhold,
  output credit_t credit_count,
  output credit_t credit_available
);

  logic active;
  logic cnt_ready;
  logic send;

  // Goes high one edge after reset is released.
  // Until then the push port refuses flits.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active <= 1'b0;
    end else begin
      active <= 1'b1;
    end
  end

  // The decrement request is qualified by active, so the counter only
  // spends a credit on a real push transfer.
  credit_counter u_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .incr_valid (link_credit),
    .decr_valid (push_valid && active),
    .decr_ready (cnt_ready),
    .withhold   (credit_withhold),
    .value      (credit_count),
    .available  (credit_available)
  );

  assign push_ready = cnt_ready && active;
  assign send       = push_valid && push_ready;

  // ----------------------------------------------------------
  // Link outputs
  // ----------------------------------------------------------

  if (`CL_REG_POP) begin : gen_reg_pop
    // The strobe is cleared at reset; data is loaded only with a flit.
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        link_valid <= 1'b0;
      end else begin
        link_valid <= send;
      end
    end

    always_ff @(posedge clk) begin
      if (send) begin
        link_data <= push_data;
      end
    end
  end else begin : gen_pass_pop
    assign link_valid = send;
    assign link_data  = push_data;
  end

endmodule

`default_nettype wire

// ==== hdl/credit_receiver.sv ====
/*
  Credit receiver: buffers link flits and presents them on a ready/valid
  pop port, returning one registered credit pulse per popped flit.
  The buffer holds CL_MAX_CREDIT flits and takes no back-pressure from the
  link; the sender's credit rule keeps it from overflowing.
*/
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_receiver import credit_link_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  link_valid,
  input  flit_t link_data,
  output logic  link_credit,
  output logic  pop_valid,
  output flit_t pop_data,
  input  logic  pop_ready
);

  // A depth of one still needs a one-bit pointer.
  localparam int PTR_W = (`CL_MAX_CREDIT > 1) ? $clog2(`CL_MAX_CREDIT) : 1;
  localparam logic [PTR_W-1:0] LAST = PTR_W'(`CL_MAX_CREDIT - 1);

  flit_t             mem [`CL_MAX_CREDIT];
  logic  [PTR_W-1:0] wr_ptr;
  logic  [PTR_W-1:0] rd_ptr;
  credit_t           occupancy;
  logic              pop_xfer;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  // Every link strobe is written; there is no full check here.
  always_ff @(posedge clk) begin
    if (link_valid) begin
      mem[wr_ptr] <= link_data;
    end
  end

  // The head entry is shown whenever the buffer is not empty.
  assign pop_valid = (occupancy != '0);
  assign pop_data  = mem[rd_ptr];
  assign pop_xfer  = pop_valid && pop_ready;

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------

  // Pointers wrap at the buffer depth, which need not be a power of two.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (link_valid) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_xfer) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  // A write and a pop at the same edge leave the occupancy unchanged.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      occupancy <= '0;
    end else begin
      case ({link_valid, pop_xfer})
        2'b10:   occupancy <= occupancy + credit_t'(1);
        2'b01:   occupancy <= occupancy - credit_t'(1);
        default: occupancy <= occupancy;
      endcase
    end
  end

  // The credit goes back one cycle after the entry is freed.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      link_credit <= 1'b0;
    end else begin
      link_credit <= pop_xfer;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/credit_link_top.sv ====
/*
  Top level of the credit link: sender and receiver on one clock and one
  asynchronous reset, joined by the valid, data and credit link wires.
*/
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_link_top import credit_link_pkg::*; (
  input  logic    clk,
  input  logic    arst_n,
  input  logic    push_valid,
  input  flit_t   push_data,
  output logic    push_ready,
  output logic    pop_valid,
  output flit_t   pop_data,
  input  logic    pop_ready,
  input  credit_t credit_withhold,
  output credit_t credit_count,
  output credit_t credit_available
);

  // Forward strobe and data, and the returning credit pulse.
  logic  link_valid;
  flit_t link_data;
  logic  link_credit;

  credit_sender u_sender (
    .clk              (clk),
    .arst_n           (arst_n),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .push_ready       (push_ready),
    .link_credit      (link_credit),
    .link_valid       (link_valid),
    .link_data        (link_data),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  credit_receiver u_receiver (
    .clk         (clk),
    .arst_n      (arst_n),
    .link_valid  (link_valid),
    .link_data   (link_data),
    .link_credit (link_credit),
    .pop_valid   (pop_valid),
    .pop_data    (pop_data),
    .pop_ready   (pop_ready)
  );

endmodule

`default_nettype wire

// ==== bench/credit_link_props.sv ====
/*
  Concurrent checks on the credit link top level, bound into each instance.
  The flit count in flight is rebuilt from the two port handshakes.
  Failures are counted in fail_count for the closing report.
*/
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_link_props import credit_link_pkg::*; (
  input logic    clk,
  input logic    arst_n,
  input logic    push_valid,
  input logic    push_ready,
  input logic    pop_valid,
  input logic    pop_ready,
  input credit_t credit_withhold,
  input credit_t credit_count,
  input credit_t credit_available
);

  int   outstanding;
  int   fail_count = 0;
  logic push_xfer;
  logic pop_xfer;

  assign push_xfer = push_valid && push_ready;
  assign pop_xfer  = pop_valid && pop_ready;

  // Flits accepted minus flits popped.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(push_xfer) - int'(pop_xfer);
    end
  end

  // The buffer can never hold more than the credit pool.
  a_bound: assert property (@(posedge clk) disable iff (!arst_n)
    outstanding <= `CL_MAX_CREDIT)
    else begin
      fail_count++;
      $error("more flits in flight than credits");
    end

  // A credit returns one cycle after a pop and may be spent at once.
  a_ready: assert property (@(posedge clk) disable iff (!arst_n)
    push_ready |-> (credit_available != '0) || $past(pop_valid && pop_ready))
    else begin
      fail_count++;
      $error("push_ready high without a credit");
    end

  // While the count covers the withhold, the spendable and withheld credits
  // add up to the count. Otherwise nothing may be spent.
  a_avail: assert property (@(posedge clk) disable iff (!arst_n)
    (credit_withhold <= credit_count) ?
      (int'(credit_available) + int'(credit_withhold) == int'(credit_count)) :
      (credit_available == '0))
    else begin
      fail_count++;
      $error("credit_available wrong for withhold");
    end

  a_reset: assert property (@(posedge clk) !arst_n |-> !push_ready && !pop_valid)
    else begin
      fail_count++;
      $error("handshake active during reset");
    end

  a_init: assert property (@(posedge clk) $rose(arst_n) |->
    credit_count == credit_t'(`CL_MAX_CREDIT))
    else begin
      fail_count++;
      $error("credit pool not full after reset");
    end

endmodule

bind credit_link_top credit_link_props props0 (
  .clk              (clk),
  .arst_n           (arst_n),
  .push_valid       (push_valid),
  .push_ready       (push_ready),
  .pop_valid        (pop_valid),
  .pop_ready        (pop_ready),
  .credit_withhold  (credit_withhold),
  .credit_count     (credit_count),
  .credit_available (credit_available)
);

`default_nettype wire

// ==== bench/credit_link_tb.sv ====
/*
  Testbench for the credit link top level.
  Random traffic, withhold fills, stall recovery and latency runs share one
  scoreboard; property checks come from the bound credit_link_props module.
  Assertions must be enabled in the simulator for those checks to count.
  Stimulus uses one fixed $urandom seed, so every run is the same.
*/
`timescale 1ns/1ps
`default_nettype none

`include "credit_link_defs.svh"

module credit_link_tb import credit_link_pkg::*; ();

  localparam int MAX_CREDIT     = `CL_MAX_CREDIT;
  localparam int RESET_CYCLES   = 8;
  localparam int N_RAND         = 200;
  localparam int N_LAT          = 2;
  localparam int STALL_CYCLES   = 3 * MAX_CREDIT + 4;
  localparam int DRAIN_LIMIT    = 4 * MAX_CREDIT + 16;
  localparam int TOTAL_FLITS    = N_RAND + (MAX_CREDIT + 1) * MAX_CREDIT + N_LAT;
  localparam int TIMEOUT_CYCLES = TOTAL_FLITS * (MAX_CREDIT + 4) + RESET_CYCLES;

  logic    clk;
  logic    arst_n;
  logic    push_valid;
  flit_t   push_data;
  logic    push_ready;
  logic    pop_valid;
  flit_t   pop_data;
  logic    pop_ready;
  credit_t credit_withhold;
  credit_t credit_count;
  credit_t credit_available;

  // Flits accepted at the push port and not yet popped, oldest first.
  flit_t expected_q[$];
  flit_t head;
  int    push_count;
  int    pop_count;
  int    sb_errors = 0;
  int    check_errors;
  string test_name;

  credit_link_top dut0 (
    .clk              (clk),
    .arst_n           (arst_n),
    .push_valid       (push_valid),
    .push_data        (push_data),
    .push_ready       (push_ready),
    .pop_valid        (pop_valid),
    .pop_data         (pop_data),
    .pop_ready        (pop_ready),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------

  // Transfers are seen at the edge that ends their cycle.
  // The counters move by NBA, so the stimulus reads stable values.
  always @(posedge clk) begin
    if (!arst_n) begin
      push_count <= 0;
      pop_count  <= 0;
    end else begin
      if (push_valid && push_ready) begin
        expected_q.push_back(push_data);
        push_count <= push_count + 1;
      end
      if (pop_valid && pop_ready) begin
        pop_count <= pop_count + 1;
        if (expected_q.size() == 0) begin
          $display("ERROR %s: a flit was popped that was never pushed", test_name);
          sb_errors++;
        end else begin
          head = expected_q.pop_front();
          if (pop_data !== head) begin
            $display("FAILED %s: expected %h, actual %h", test_name, head, pop_data);
            sb_errors++;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------

  // New data is offered only after a transfer, so a stalled flit holds.
  task automatic drive_cycle(input bit want_push, input bit want_pop);
    @(posedge clk);
    if (!want_push) begin
      push_valid <= 1'b0;
    end else if (!push_valid || push_ready) begin
      push_valid <= 1'b1;
      push_data  <= flit_t'($urandom);
    end
    pop_ready <= want_pop;
  endtask

  // A full credit pool means nothing is left in the register or buffer.
  task automatic drain_link();
    int n;
    n = 0;
    drive_cycle(1'b0, 1'b1);
    credit_withhold <= '0;
    while ((push_count != pop_count || credit_count != credit_t'(MAX_CREDIT)) &&
           n < DRAIN_LIMIT) begin
      drive_cycle(1'b0, 1'b1);
      n++;
    end
    if (n >= DRAIN_LIMIT) begin
      $display("ERROR %s: the link did not drain back to idle", test_name);
      check_errors++;
    end
  endtask

  task automatic random_traffic();
    int target;
    test_name = "random";
    target = push_count + N_RAND;
    while (push_count < target) begin
      drive_cycle(($urandom % 4) != 0, ($urandom % 2) != 0);
      if (($urandom % 16) == 0) begin
        credit_withhold <= credit_t'($urandom % (MAX_CREDIT + 1));
      end
    end
  endtask

  // With pops stalled, only the credits not withheld can be spent.
  task automatic stall_fill(input int w);
    int start_count;
    int accepted;
    int expect_count;
    test_name = "withhold";
    drive_cycle(1'b0, 1'b0);
    credit_withhold <= credit_t'(w);
    start_count = push_count;
    repeat (STALL_CYCLES) drive_cycle(1'b1, 1'b0);
    drive_cycle(1'b0, 1'b0);
    drive_cycle(1'b0, 1'b0);
    accepted = push_count - start_count;
    expect_count = (MAX_CREDIT > w) ? MAX_CREDIT - w : 0;
    if (accepted != expect_count) begin
      $display("FAILED withhold: expected %0d, actual %0d", expect_count, accepted);
      check_errors++;
    end
    if (push_ready) begin
      $display("ERROR withhold: push_ready stayed high with no credit left");
      check_errors++;
    end
    test_name = "recovery";
    drain_link();
  endtask

  // Counts edges from the push transfer to the first sampled pop_valid.
  task automatic check_latency();
    int n;
    test_name = "latency";
    @(posedge clk);
    push_valid <= 1'b1;
    push_data  <= flit_t'($urandom);
    pop_ready  <= 1'b1;
    @(posedge clk);
    push_valid <= 1'b0;
    if (!push_ready) begin
      $display("ERROR latency: a push on an idle link was not accepted");
      check_errors++;
    end
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!pop_valid && n < 8);
    if (n != 1 + `CL_REG_POP) begin
      $display("FAILED latency: expected %0d, actual %0d", 1 + `CL_REG_POP, n);
      check_errors++;
    end
    drain_link();
  endtask

  // ----------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------

  initial begin
    void'($urandom(32'hd9cf0ed6));
    arst_n          = 1'b0;
    push_valid      = 1'b0;
    push_data       = '0;
    pop_ready       = 1'b0;
    credit_withhold = '0;
    check_errors    = 0;
    test_name       = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    drive_cycle(1'b0, 1'b0);
    random_traffic();
    drain_link();
    for (int w = 0; w <= MAX_CREDIT; w++) begin
      stall_fill(w);
    end
    repeat (N_LAT) check_latency();
    $display("Errors: scoreboard %0d, checks %0d, assertions %0d",
             sb_errors, check_errors, dut0.props0.fail_count);
    if (sb_errors + check_errors + dut0.props0.fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("ERROR watchdog: the run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/credit_link_pkg.sv
hdl/credit_counter.sv
hdl/credit_sender.sv
hdl/credit_receiver.sv
hdl/credit_link_top.sv
bench/credit_link_props.sv
bench/credit_link_tb.sv

// ==== Makefile ====
# Verilator build and run for the credit link testbench.
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= credit_link_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= filelist.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
